/* sim/xgpon_bridge_vectors.txt */
# T name | C addr data | L loop | F n words.. | R n (valid data).. | N count | E errs | V words lasts
# all numbers hex
T default_framing
F 4 11110001 11110002 11110003 11110004
V 0 0
T loopback
L 1
F 3 22220001 22220002 22220003
F 1 22220010
F 6 22220021 22220022 22220023 22220024 22220025 22220026
N 3
T short_preamble
L 0
R 6 1 05560556 1 05560556 1 05560556 1 05560556 1 aaaa0001 1 3c5aa5c3
V 0 0
N 3
T broken_burst
R 9 1 05560556 1 05560556 1 05560556 1 05560556 1 05560556 1 bbbb0001 1 bbbb0002 1 bbbb0003 0 0
E 1
V 2 0
R 9 1 05560556 1 05560556 1 05560556 1 05560556 1 05560556 1 05560556 1 cccc0001 1 cccc0002 1 3c5aa5c3
V 2 1
N 4
E 1
T reconfig
C 0 6
C 1 a5a5f00f
C 2 0f0fc3c3
L 1
F 5 dddd0001 dddd0002 dddd0003 dddd0004 dddd0005
N 5
T clamp
C 0 14
F 2 eeee0001 eeee0002
N 6
E 1

/* xgpon_bridge_top.f */
common/xgpon_bridge_pkg.sv
source/burst_config_regs.sv
framer/burst_framer.sv
deframer/burst_deframer.sv
source/xgpon_bridge_top.sv
sim/xgpon_bridge_sva.sv
sim/xgpon_bridge_tb.sv

/* Makefile */
# Verilator build for the xgpon bridge testbench

VERILATOR ?= verilator
TOP       ?= xgpon_bridge_tb
RTL_TOP   ?= xgpon_bridge_top
FILELIST  ?= xgpon_bridge_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^test passed$$" $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/xgpon_bridge_tb.sv */
`timescale 1ns/1ps

module xgpon_bridge_tb;

    localparam int MAX_PRE_LEN    = 16;
    localparam int SYNC_THRESHOLD = 5;
    localparam int MAX_GAP        = MAX_PRE_LEN + 8;   // idle after a frame, worst case

    logic                         axis_clk = 1'b0;
    logic                         rst_n;
    logic                         cfg_wr;
    xgpon_bridge_pkg::cfg_addr_t  cfg_addr;
    xgpon_bridge_pkg::pon_word_t  cfg_wdata;
    xgpon_bridge_pkg::pon_word_t  eth_rx_data;
    logic                         eth_rx_valid;
    logic                         eth_rx_last;
    xgpon_bridge_pkg::pon_word_t  pon_tx_data;
    logic                         pon_tx_valid;
    xgpon_bridge_pkg::pon_word_t  pon_rx_data;
    logic                         pon_rx_valid;
    xgpon_bridge_pkg::pon_word_t  eth_tx_data;
    logic                         eth_tx_valid;
    logic                         eth_tx_last;
    logic                         burst_error;
    xgpon_bridge_pkg::frame_cnt_t frame_count;

    logic                         loop_en;     // pon_tx fed back into pon_rx
    xgpon_bridge_pkg::pon_word_t  raw_data;
    logic                         raw_valid;
    xgpon_bridge_pkg::pon_word_t  pon_seen[$];
    xgpon_bridge_pkg::pon_word_t  eth_seen[$];
    logic                         eth_last_q[$];
    int                           err_cnt = 0;
    int                           cycles = 0;
    int                           limit = 0;   // 0 until vectors are parsed
    string                        cur_test = "none";

    // reference model of the config registers
    int                           m_pre_len   = xgpon_bridge_pkg::DEFAULT_PRE_LEN;
    xgpon_bridge_pkg::pon_word_t  m_pre_pat   = xgpon_bridge_pkg::DEFAULT_PRE_PAT;
    xgpon_bridge_pkg::pon_word_t  m_trail_pat = xgpon_bridge_pkg::DEFAULT_TRAIL_PAT;

    string                        ops[$];
    string                        names[$];
    logic [31:0]                  vals[$];

    always #50 axis_clk = ~axis_clk;

    xgpon_bridge_top #(
        .MAX_PRE_LEN    (MAX_PRE_LEN),
        .SYNC_THRESHOLD (SYNC_THRESHOLD)
    ) xgpon_bridge_top_inst (
        .axis_clk     (axis_clk),
        .rst_n        (rst_n),
        .cfg_wr       (cfg_wr),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .eth_rx_data  (eth_rx_data),
        .eth_rx_valid (eth_rx_valid),
        .eth_rx_last  (eth_rx_last),
        .pon_tx_data  (pon_tx_data),
        .pon_tx_valid (pon_tx_valid),
        .pon_rx_data  (pon_rx_data),
        .pon_rx_valid (pon_rx_valid),
        .eth_tx_data  (eth_tx_data),
        .eth_tx_valid (eth_tx_valid),
        .eth_tx_last  (eth_tx_last),
        .burst_error  (burst_error),
        .frame_count  (frame_count)
    );

    ////////////////////
    // pon rx source and monitors
    ////////////////////

    always @(posedge axis_clk) begin
        pon_rx_data  <= loop_en ? pon_tx_data : raw_data;
        pon_rx_valid <= loop_en ? pon_tx_valid : raw_valid;
    end

    // outputs taken at the edge, before the dut updates them
    always @(posedge axis_clk) begin
        if (rst_n) begin
            if (pon_tx_valid) pon_seen.push_back(pon_tx_data);
            if (eth_tx_valid) begin
                eth_seen.push_back(eth_tx_data);
                eth_last_q.push_back(eth_tx_last);
            end
            if (burst_error) err_cnt++;
        end
    end

    always @(posedge axis_clk) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("test failed");
            $fatal(1);
        end
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("Error %s (%s): expected %h actual %h", cur_test, what, exp, act);
            $display("test failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] read_hex(input int fd);
        logic [31:0] v;
        v = '0;
        void'($fscanf(fd, "%h", v));
        return v;
    endfunction

    task automatic write_config(input logic [31:0] addr, input logic [31:0] data);
        @(posedge axis_clk);
        cfg_wr    <= 1'b1;
        cfg_addr  <= addr[1:0];
        cfg_wdata <= data;
        @(posedge axis_clk);
        cfg_wr <= 1'b0;
        case (addr[1:0])
            xgpon_bridge_pkg::CFG_ADDR_PRE_LEN:
                m_pre_len = (data > MAX_PRE_LEN) ? MAX_PRE_LEN : ((data == 0) ? 1 : data);
            xgpon_bridge_pkg::CFG_ADDR_PRE_PAT:   m_pre_pat = data;
            xgpon_bridge_pkg::CFG_ADDR_TRAIL_PAT: m_trail_pat = data;
            default: ;   // unmapped address
        endcase
    endtask

    task automatic send_frame(input int n);
        logic [31:0] words[$];
        int          exp_len;
        for (int i = 0; i < n; i++) words.push_back(vals.pop_front());
        exp_len = m_pre_len + n + 1;
        for (int i = 0; i < n; i++) begin
            @(posedge axis_clk);
            eth_rx_valid <= 1'b1;
            eth_rx_data  <= words[i];
            eth_rx_last  <= (i == n - 1);
        end
        @(posedge axis_clk);
        eth_rx_valid <= 1'b0;
        eth_rx_last  <= 1'b0;
        while (pon_seen.size() < exp_len) @(posedge axis_clk);
        if (loop_en) begin
            while (eth_seen.size() < n || !eth_last_q[eth_last_q.size() - 1]) begin
                @(posedge axis_clk);
            end
        end
        repeat (m_pre_len + 2 + $urandom % 4) @(posedge axis_clk);   // gap between frames
        // burst shape: preamble run, payload, trailer
        check_value("burst length", exp_len, pon_seen.size());
        for (int i = 0; i < m_pre_len; i++) check_value("preamble", m_pre_pat, pon_seen[i]);
        for (int i = 0; i < n; i++) check_value("payload", words[i], pon_seen[m_pre_len + i]);
        check_value("trailer", m_trail_pat, pon_seen[exp_len - 1]);
        pon_seen.delete();
        if (loop_en) begin
            check_value("rx length", n, eth_seen.size());
            for (int i = 0; i < n; i++) begin
                check_value("rx word", words[i], eth_seen[i]);
                check_value("rx last", (i == n - 1), eth_last_q[i]);
            end
            eth_seen.delete();
            eth_last_q.delete();
        end
    endtask

    task automatic send_raw(input int n);
        logic [31:0] flag;
        for (int i = 0; i < n; i++) begin
            @(posedge axis_clk);
            flag = vals.pop_front();
            raw_valid <= flag[0];
            raw_data  <= vals.pop_front();
        end
        @(posedge axis_clk);
        raw_valid <= 1'b0;
        repeat (4) @(posedge axis_clk);   // let the deframer drain
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        int          fd;
        int          n;
        int          lasts;
        int          total;
        logic [31:0] flag;
        string       tok;
        string       line;
        string       name;
        rst_n        = 1'b0;
        cfg_wr       = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        eth_rx_data  = '0;
        eth_rx_valid = 1'b0;
        eth_rx_last  = 1'b0;
        pon_rx_data  = '0;
        pon_rx_valid = 1'b0;
        loop_en      = 1'b0;
        raw_data     = '0;
        raw_valid    = 1'b0;
        void'($urandom(32'h56ac));
        total = 10;
        fd = $fopen("sim/xgpon_bridge_vectors.txt", "r");
        if (fd == 0) begin
            $display("vector file sim/xgpon_bridge_vectors.txt could not be opened");
            $display("test failed");
            $fatal(1);
        end
        // whole file parsed first so the timeout is known up front
        while (!$feof(fd)) begin
            if ($fscanf(fd, "%s", tok) != 1) break;
            if (tok == "#") begin
                void'($fgets(line, fd));
                continue;
            end
            ops.push_back(tok);
            case (tok)
                "T": begin
                    void'($fscanf(fd, "%s", name));
                    names.push_back(name);
                end
                "C", "V": begin
                    vals.push_back(read_hex(fd));
                    vals.push_back(read_hex(fd));
                    total += 2;
                end
                "L", "N", "E": vals.push_back(read_hex(fd));
                "F": begin
                    n = read_hex(fd);
                    vals.push_back(n);
                    for (int i = 0; i < n; i++) vals.push_back(read_hex(fd));
                    total += MAX_PRE_LEN + n + 1 + MAX_GAP;
                end
                "R": begin
                    n = read_hex(fd);
                    vals.push_back(n);
                    for (int i = 0; i < 2 * n; i++) vals.push_back(read_hex(fd));
                    total += n + MAX_GAP;
                end
                default: begin
                    $display("unknown command %s in vector file", tok);
                    $display("test failed");
                    $fatal(1);
                end
            endcase
        end
        $fclose(fd);
        limit = 2 * total;

        repeat (10) @(posedge axis_clk);
        rst_n <= 1'b1;
        @(posedge axis_clk);

        foreach (ops[k]) begin
            case (ops[k])
                "T": cur_test = names.pop_front();
                "C": begin
                    n = vals.pop_front();
                    write_config(n, vals.pop_front());
                end
                "L": begin
                    @(posedge axis_clk);
                    flag = vals.pop_front();
                    loop_en <= flag[0];
                end
                "F": send_frame(vals.pop_front());
                "R": send_raw(vals.pop_front());
                "N": check_value("frame_count", vals.pop_front(), frame_count);
                "E": check_value("burst_error pulses", vals.pop_front(), err_cnt);
                "V": begin
                    lasts = 0;
                    foreach (eth_last_q[i]) lasts += eth_last_q[i];
                    check_value("rx words", vals.pop_front(), eth_seen.size());
                    check_value("rx lasts", vals.pop_front(), lasts);
                    eth_seen.delete();
                    eth_last_q.delete();
                end
                default: ;
            endcase
        end
        $display("test passed");
        $finish;
    end

endmodule

/* sim/xgpon_bridge_sva.sv */
`timescale 1ns/1ps

module xgpon_bridge_sva (
    input logic                        axis_clk,
    input logic                        rst_n,
    input logic                        tx_valid,    // framer burst strobe
    input xgpon_bridge_pkg::pon_word_t tx_data,
    input xgpon_bridge_pkg::pon_word_t trail_pat,
    input logic                        rx_valid,    // deframer output strobe
    input logic                        rx_last,
    input logic                        rx_error
);

    // last marker never alone
    assert property (@(posedge axis_clk) disable iff (!rst_n) rx_last |-> rx_valid)
        else $error("last without valid");

    // no hole from first preamble word up to and including the trailer
    assert property (@(posedge axis_clk) disable iff (!rst_n)
                     (tx_valid && (tx_data != trail_pat)) |=> tx_valid)
        else $error("valid dropped inside burst");

    assert property (@(posedge axis_clk) disable iff (!rst_n) rx_error |-> !rx_valid)
        else $error("error pulse together with valid");

endmodule

bind xgpon_bridge_top xgpon_bridge_sva bridge_sva_inst (
    .axis_clk  (axis_clk),
    .rst_n     (rst_n),
    .tx_valid  (pon_tx_valid),
    .tx_data   (pon_tx_data),
    .trail_pat (trail_pat),
    .rx_valid  (eth_tx_valid),
    .rx_last   (eth_tx_last),
    .rx_error  (burst_error)
);

/* source/xgpon_bridge_top.sv */
`timescale 1ns/1ps

module xgpon_bridge_top #(
    parameter int MAX_PRE_LEN    = 16,  // cap on preamble duration
    parameter int SYNC_THRESHOLD = 5    // sync words needed by deframer
) (
    input  logic                          axis_clk,
    input  logic                          rst_n,
    // config write port
    input  logic                          cfg_wr,
    input  xgpon_bridge_pkg::cfg_addr_t   cfg_addr,
    input  xgpon_bridge_pkg::pon_word_t   cfg_wdata,
    // ethernet in, pon burst out
    input  xgpon_bridge_pkg::pon_word_t   eth_rx_data,
    input  logic                          eth_rx_valid,
    input  logic                          eth_rx_last,
    output xgpon_bridge_pkg::pon_word_t   pon_tx_data,
    output logic                          pon_tx_valid,
    // pon burst in, ethernet out
    input  xgpon_bridge_pkg::pon_word_t   pon_rx_data,
    input  logic                          pon_rx_valid,
    output xgpon_bridge_pkg::pon_word_t   eth_tx_data,
    output logic                          eth_tx_valid,
    output logic                          eth_tx_last,
    output logic                          burst_error,
    output xgpon_bridge_pkg::frame_cnt_t  frame_count
);

    xgpon_bridge_pkg::pre_len_t  pre_len;     // shared by framer only
    xgpon_bridge_pkg::pon_word_t pre_pat;     // framer and deframer
    xgpon_bridge_pkg::pon_word_t trail_pat;   // framer and deframer

    ////////////////////
    // config registers
    ////////////////////

    burst_config_regs #(
        .MAX_PRE_LEN (MAX_PRE_LEN)
    ) burst_config_regs_inst (
        .axis_clk  (axis_clk),
        .rst_n     (rst_n),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .pre_len   (pre_len),
        .pre_pat   (pre_pat),
        .trail_pat (trail_pat)
    );

    ////////////////////
    // eth -> pon
    ////////////////////

    burst_framer #(
        .MAX_PRE_LEN (MAX_PRE_LEN)
    ) burst_framer_inst (
        .axis_clk     (axis_clk),
        .rst_n        (rst_n),
        .eth_rx_data  (eth_rx_data),
        .eth_rx_valid (eth_rx_valid),
        .eth_rx_last  (eth_rx_last),
        .pre_len      (pre_len),
        .pre_pat      (pre_pat),
        .trail_pat    (trail_pat),
        .pon_tx_data  (pon_tx_data),
        .pon_tx_valid (pon_tx_valid)
    );

    ////////////////////
    // pon -> eth
    ////////////////////

    burst_deframer #(
        .SYNC_THRESHOLD (SYNC_THRESHOLD)
    ) burst_deframer_inst (
        .axis_clk     (axis_clk),
        .rst_n        (rst_n),
        .pon_rx_data  (pon_rx_data),
        .pon_rx_valid (pon_rx_valid),
        .pre_pat      (pre_pat),
        .trail_pat    (trail_pat),
        .eth_tx_data  (eth_tx_data),
        .eth_tx_valid (eth_tx_valid),
        .eth_tx_last  (eth_tx_last),
        .burst_error  (burst_error),
        .frame_count  (frame_count)
    );

endmodule

/* deframer/burst_deframer.sv */
`timescale 1ns/1ps

module burst_deframer #(
    parameter int SYNC_THRESHOLD = 5
) (
    input  logic                          axis_clk,
    input  logic                          rst_n,
    input  xgpon_bridge_pkg::pon_word_t   pon_rx_data,
    input  logic                          pon_rx_valid,
    input  xgpon_bridge_pkg::pon_word_t   pre_pat,
    input  xgpon_bridge_pkg::pon_word_t   trail_pat,
    output xgpon_bridge_pkg::pon_word_t   eth_tx_data,
    output logic                          eth_tx_valid,
    output logic                          eth_tx_last,
    output logic                          burst_error,
    output xgpon_bridge_pkg::frame_cnt_t  frame_count
);

    localparam int               CNT_W    = $clog2(SYNC_THRESHOLD + 1);
    localparam logic [CNT_W-1:0] SYNC_MAX = CNT_W'(SYNC_THRESHOLD);

    xgpon_bridge_pkg::deframer_state_t state;
    xgpon_bridge_pkg::pon_word_t       hold_word;   // one word held back
    logic [CNT_W-1:0]                  sync_cnt;    // consecutive preamble words
    logic                              is_pre;
    logic                              is_trail;
    logic                              synced;

    assign is_pre   = pon_rx_valid && (pon_rx_data == pre_pat);
    assign is_trail = (pon_rx_data == trail_pat);
    assign synced   = (sync_cnt == SYNC_MAX);

    ////////////////////
    // data path
    ////////////////////

    // hold reg takes every valid word, only read while in payload
    always_ff @(posedge axis_clk) begin
        if (pon_rx_valid) begin
            hold_word <= pon_rx_data;
        end
    end

    // held word leaves when its successor arrives
    always_ff @(posedge axis_clk) begin
        if (state == xgpon_bridge_pkg::DF_PAYLOAD && pon_rx_valid) begin
            eth_tx_data <= hold_word;
        end
    end

    ////////////////////
    // hunt / payload fsm
    ////////////////////

    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= xgpon_bridge_pkg::DF_HUNT;
            sync_cnt     <= '0;
            eth_tx_valid <= 1'b0;
            eth_tx_last  <= 1'b0;
            burst_error  <= 1'b0;
            frame_count  <= '0;
        end else begin
            eth_tx_valid <= 1'b0;   // strobes, one cycle each
            eth_tx_last  <= 1'b0;
            burst_error  <= 1'b0;
            case (state)
                xgpon_bridge_pkg::DF_HUNT: begin
                    if (is_pre) begin
                        if (!synced) begin
                            sync_cnt <= sync_cnt + 1'b1;   // saturates at threshold
                        end
                    end else begin
                        sync_cnt <= '0;                    // gap or other word breaks run
                        // first non-sync word after lock is payload word 0
                        if (synced && pon_rx_valid && !is_trail) begin
                            state <= xgpon_bridge_pkg::DF_PAYLOAD;
                        end
                    end
                end
                xgpon_bridge_pkg::DF_PAYLOAD: begin
                    if (!pon_rx_valid) begin
                        burst_error <= 1'b1;               // burst cut short, no last
                        state       <= xgpon_bridge_pkg::DF_HUNT;
                    end else begin
                        eth_tx_valid <= 1'b1;
                        if (is_trail) begin
                            eth_tx_last <= 1'b1;           // held word closes the frame
                            frame_count <= frame_count + 1'b1;
                            state       <= xgpon_bridge_pkg::DF_HUNT;
                        end
                    end
                end
                default: state <= xgpon_bridge_pkg::DF_HUNT;
            endcase
        end
    end

endmodule

/* framer/burst_framer.sv */
`timescale 1ns/1ps

module burst_framer #(
    parameter int MAX_PRE_LEN = 16
) (
    input  logic                          axis_clk,
    input  logic                          rst_n,
    input  xgpon_bridge_pkg::pon_word_t   eth_rx_data,
    input  logic                          eth_rx_valid,
    input  logic                          eth_rx_last,
    input  xgpon_bridge_pkg::pre_len_t    pre_len,
    input  xgpon_bridge_pkg::pon_word_t   pre_pat,
    input  xgpon_bridge_pkg::pon_word_t   trail_pat,
    output xgpon_bridge_pkg::pon_word_t   pon_tx_data,
    output logic                          pon_tx_valid
);

    localparam int DEPTH = MAX_PRE_LEN + 2;   // covers pre_len words in flight plus slack
    localparam int PTR_W = $clog2(DEPTH);
    localparam int LEN_W = 16;                // frame length counters

    xgpon_bridge_pkg::pon_word_t     buf_mem [DEPTH];
    xgpon_bridge_pkg::framer_state_t state;
    xgpon_bridge_pkg::pre_len_t      pre_cnt;     // preamble words still to send
    logic [PTR_W-1:0]                wr_ptr;
    logic [PTR_W-1:0]                rd_ptr;
    logic [LEN_W-1:0]                in_cnt;      // words taken in this frame
    logic [LEN_W-1:0]                out_cnt;     // words sent in this frame
    logic [LEN_W-1:0]                frame_len;
    logic                            len_known;   // eth_rx_last seen for current frame
    logic                            frame_start;
    logic                            last_rd;

    // circular pointer step, depth is not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign frame_start = (state == xgpon_bridge_pkg::FR_IDLE) && eth_rx_valid;
    assign last_rd     = len_known && (out_cnt == frame_len - 1'b1);

    ////////////////////
    // input side
    ////////////////////

    always_ff @(posedge axis_clk) begin
        if (eth_rx_valid) begin
            buf_mem[wr_ptr] <= eth_rx_data;
        end
    end

    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            in_cnt    <= '0;
            frame_len <= '0;
            len_known <= 1'b0;
        end else if (eth_rx_valid) begin
            wr_ptr <= ptr_inc(wr_ptr);
            if (eth_rx_last) begin
                frame_len <= in_cnt + 1'b1;     // length noted on the last word
                in_cnt    <= '0;
                len_known <= 1'b1;
            end else begin
                in_cnt <= in_cnt + 1'b1;
                if (frame_start) begin
                    len_known <= 1'b0;          // forget previous frame
                end
            end
        end
    end

    ////////////////////
    // burst output fsm
    ////////////////////

    // output lags input by pre_len + 1 so payload drains with no gaps
    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= xgpon_bridge_pkg::FR_IDLE;
            pon_tx_data  <= '0;
            pon_tx_valid <= 1'b0;
            pre_cnt      <= '0;
            rd_ptr       <= '0;
            out_cnt      <= '0;
        end else begin
            case (state)
                xgpon_bridge_pkg::FR_IDLE: begin
                    pon_tx_valid <= frame_start;
                    pon_tx_data  <= pre_pat;          // first preamble word
                    if (frame_start) begin
                        pre_cnt <= pre_len - 1'b1;
                        rd_ptr  <= wr_ptr;            // word 0 lands here this cycle
                        out_cnt <= '0;
                        state   <= (pre_len == 8'd1) ? xgpon_bridge_pkg::FR_PAYLOAD
                                                     : xgpon_bridge_pkg::FR_PREAMBLE;
                    end
                end
                xgpon_bridge_pkg::FR_PREAMBLE: begin
                    pon_tx_data <= pre_pat;
                    pre_cnt     <= pre_cnt - 1'b1;
                    if (pre_cnt == 8'd1) begin
                        state <= xgpon_bridge_pkg::FR_PAYLOAD;
                    end
                end
                xgpon_bridge_pkg::FR_PAYLOAD: begin
                    pon_tx_data <= buf_mem[rd_ptr];
                    rd_ptr      <= ptr_inc(rd_ptr);
                    out_cnt     <= out_cnt + 1'b1;
                    if (last_rd) begin
                        state <= xgpon_bridge_pkg::FR_TRAILER;
                    end
                end
                xgpon_bridge_pkg::FR_TRAILER: begin
                    pon_tx_data <= trail_pat;         // valid drops next cycle in idle
                    state       <= xgpon_bridge_pkg::FR_IDLE;
                end
                default: state <= xgpon_bridge_pkg::FR_IDLE;
            endcase
        end
    end

endmodule

/* source/burst_config_regs.sv */
`timescale 1ns/1ps

module burst_config_regs #(
    parameter int MAX_PRE_LEN = 16
) (
    input  logic                          axis_clk,
    input  logic                          rst_n,
    input  logic                          cfg_wr,
    input  xgpon_bridge_pkg::cfg_addr_t   cfg_addr,
    input  xgpon_bridge_pkg::pon_word_t   cfg_wdata,
    output xgpon_bridge_pkg::pre_len_t    pre_len,
    output xgpon_bridge_pkg::pon_word_t   pre_pat,
    output xgpon_bridge_pkg::pon_word_t   trail_pat
);

    xgpon_bridge_pkg::pre_len_t len_clamped;   // write data forced into 1..MAX_PRE_LEN

    // whole 32 bit value compared, so big writes clamp instead of wrapping
    always_comb begin
        if (cfg_wdata > xgpon_bridge_pkg::pon_word_t'(MAX_PRE_LEN)) begin
            len_clamped = xgpon_bridge_pkg::pre_len_t'(MAX_PRE_LEN);
        end else if (cfg_wdata == '0) begin
            len_clamped = 8'd1;                 // zero length preamble not allowed
        end else begin
            len_clamped = xgpon_bridge_pkg::pre_len_t'(cfg_wdata);
        end
    end

    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_len   <= xgpon_bridge_pkg::DEFAULT_PRE_LEN;
            pre_pat   <= xgpon_bridge_pkg::DEFAULT_PRE_PAT;
            trail_pat <= xgpon_bridge_pkg::DEFAULT_TRAIL_PAT;
        end else if (cfg_wr) begin
            case (cfg_addr)
                xgpon_bridge_pkg::CFG_ADDR_PRE_LEN:   pre_len   <= len_clamped;
                xgpon_bridge_pkg::CFG_ADDR_PRE_PAT:   pre_pat   <= cfg_wdata;
                xgpon_bridge_pkg::CFG_ADDR_TRAIL_PAT: trail_pat <= cfg_wdata;
                default: ;                      // addr 3, write dropped
            endcase
        end
    end

endmodule

/* common/xgpon_bridge_pkg.sv */
package xgpon_bridge_pkg;

    ////////////////////
    // data types
    ////////////////////

    typedef logic [31:0] pon_word_t;     // one stream word, eth and pon side alike
    typedef logic [7:0]  pre_len_t;      // preamble duration in words
    typedef logic [1:0]  cfg_addr_t;     // config register address
    typedef logic [15:0] frame_cnt_t;    // good frames seen by the deframer

    ////////////////////
    // register map
    ////////////////////

    localparam cfg_addr_t CFG_ADDR_PRE_LEN   = 2'd0;  // preamble duration
    localparam cfg_addr_t CFG_ADDR_PRE_PAT   = 2'd1;  // preamble word
    localparam cfg_addr_t CFG_ADDR_TRAIL_PAT = 2'd2;  // frame trailer word
    // address 3 is not decoded

    // Preamble duration after reset, in words.
    localparam pre_len_t  DEFAULT_PRE_LEN   = 8'd8;
    // Preamble word after reset, the 0556 burst sync pattern in both halves.
    localparam pon_word_t DEFAULT_PRE_PAT   = 32'h0556_0556;
    // Trailer word after reset, chosen well away from the sync pattern.
    localparam pon_word_t DEFAULT_TRAIL_PAT = 32'h3C5A_A5C3;

    ////////////////////
    // fsm encodings
    ////////////////////

    typedef enum logic [1:0] {
        FR_IDLE,        // waiting for a frame start
        FR_PREAMBLE,    // sync words going out
        FR_PAYLOAD,     // buffered words going out
        FR_TRAILER      // trailer word next
    } framer_state_t;

    typedef enum logic {
        DF_HUNT,        // looking for preamble run
        DF_PAYLOAD      // locked, forwarding words
    } deframer_state_t;

endpackage
